// ==== verilog.f ====
+incdir+src
src/tl_msg_pkg.sv
src/tl_cover_pkg.sv
src/tl_tap_capture.sv
src/tl_beat_history.sv
src/tl_event_counter.sv
src/tl_link_monitor.sv
verification/tl_link_monitor_scoreboard.sv
verification/tl_link_monitor_chk.sv
verification/tl_link_monitor_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the TL-UL link monitor testbench with Verilator and runs it.
# The run passes only if the testbench prints its pass message.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f --top-module tl_link_monitor_tb

output=$(./obj_dir/Vtl_link_monitor_tb) || true
echo "$output"
echo "$output" | grep -qx "Result: PASSED"

// ==== verification/tl_link_monitor_tb.sv ====
// Testbench of the TL-UL link monitor.
// Drives seeded random A and D traffic and reads every counter after each test.

`timescale 1ns/1ns

`include "tl_monitor_settings.svh"

module tl_link_monitor_tb;

  import tl_msg_pkg::*;
  import tl_cover_pkg::*;

  localparam int RESET_CYCLES  = 4;
  localparam int DRAIN_CYCLES  = 4;
  localparam int A_ONLY_CYCLES = 400;
  localparam int D_ONLY_CYCLES = 400;
  localparam int MIXED_CYCLES  = 600;
  localparam int CLEAR_CYCLES  = 600;
  // A readout sweep goes idle, drains the pipeline and reads every event once.
  localparam int SWEEP_CYCLES  = 1 + DRAIN_CYCLES + TL_NUM_EVENTS;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + A_ONLY_CYCLES + D_ONLY_CYCLES +
                                  MIXED_CYCLES + CLEAR_CYCLES + 5 * SWEEP_CYCLES + 200;

  logic                        clk_i     = 1'b0;
  logic                        arst_n    = 1'b0;
  logic                        a_valid   = 1'b0;
  logic                        a_ready   = 1'b0;
  tl_a_opcode_e                a_opcode  = PutFullData;
  logic [`TL_SIZE_WIDTH-1:0]   a_size    = '0;
  logic [`TL_SOURCE_WIDTH-1:0] a_source  = '0;
  logic [`TL_ADDR_WIDTH-1:0]   a_address = '0;
  logic [`TL_DATA_WIDTH-1:0]   a_data    = '0;
  logic                        a_corrupt = 1'b0;
  logic                        d_valid   = 1'b0;
  logic                        d_ready   = 1'b0;
  tl_d_opcode_e                d_opcode  = AccessAck;
  logic [`TL_SIZE_WIDTH-1:0]   d_size    = '0;
  logic [`TL_SOURCE_WIDTH-1:0] d_source  = '0;
  logic [`TL_SINK_WIDTH-1:0]   d_sink    = '0;
  logic [`TL_DATA_WIDTH-1:0]   d_data    = '0;
  logic                        d_corrupt = 1'b0;
  logic                        d_denied  = 1'b0;
  logic                        clear     = 1'b0;
  logic                        check_en  = 1'b0;
  tl_event_e                   event_sel = EV_A_BACK_TO_BACK;
  logic [`TL_COUNT_WIDTH-1:0]  event_count;

  // Small pools make repeated and changed fields both frequent.
  logic [`TL_SOURCE_WIDTH-1:0] source_pool  [4] = '{4'h1, 4'h3, 4'h7, 4'hc};
  logic [`TL_ADDR_WIDTH-1:0]   address_pool [4] = '{32'h0000_1000, 32'h0000_1004,
                                                    32'h8000_0000, 32'hffff_fffc};
  logic [`TL_DATA_WIDTH-1:0]   data_pool    [4] = '{32'h0000_0000, 32'hdead_beef,
                                                    32'h1234_5678, 32'hffff_ffff};

  integer seed         = 32'h4e19;
  int     sb_errors;
  int     errors_seen  = 0;
  int     tests_passed = 0;
  int     tests_failed = 0;

  tl_link_monitor tl_link_monitor_i (.*);

  tl_link_monitor_scoreboard scoreboard_i (.*, .error_count(sb_errors));

  initial begin
    forever #10 clk_i = ~clk_i;
  end

  function automatic int rand_below(input int limit);
    return $unsigned($random(seed)) % limit;
  endfunction

  function automatic tl_a_opcode_e pick_a_opcode(input logic [1:0] idx);
    case (idx)
      2'd0: return PutFullData;
      2'd1: return PutPartialData;
      default: return Get;
    endcase
  endfunction

  // A declined beat is often offered again unchanged, as a real master would.
  task automatic drive_a_beat(input int ready_pct);
    logic        hold;
    logic [31:0] r;
    hold = a_valid && !a_ready && rand_below(2) == 0;
    r = $random(seed);
    a_valid <= rand_below(100) < 70;
    a_ready <= rand_below(100) < ready_pct;
    if (!hold) begin
      a_opcode  <= pick_a_opcode(r[1:0]);
      a_size    <= r[3:2];
      a_source  <= source_pool[r[5:4]];
      a_address <= address_pool[r[7:6]];
      a_data    <= data_pool[r[9:8]];
      a_corrupt <= r[12:10] == 3'd0;
    end
  endtask

  task automatic drive_d_beat(input int ready_pct);
    logic        hold;
    logic [31:0] r;
    hold = d_valid && !d_ready && rand_below(2) == 0;
    r = $random(seed);
    d_valid <= rand_below(100) < 70;
    d_ready <= rand_below(100) < ready_pct;
    if (!hold) begin
      d_opcode  <= r[0] ? AccessAckData : AccessAck;
      d_size    <= r[3:2];
      d_source  <= source_pool[r[5:4]];
      d_sink    <= r[10];
      d_data    <= data_pool[r[9:8]];
      d_corrupt <= r[13:11] == 3'd0;
      d_denied  <= r[16:14] == 3'd0;
    end
  endtask

  // Clear is pulsed in cycle clear_at, or never when it is negative.
  task automatic drive_traffic(input int cycles, input bit use_a, input bit use_d,
                               input int ready_pct, input int clear_at);
    for (int c = 0; c < cycles; c++) begin
      @(posedge clk_i);
      clear <= (c == clear_at);
      if (use_a) drive_a_beat(ready_pct);
      if (use_d) drive_d_beat(ready_pct);
    end
  endtask

  task automatic sweep_counters();
    @(posedge clk_i);
    a_valid <= 1'b0;
    a_ready <= 1'b0;
    d_valid <= 1'b0;
    d_ready <= 1'b0;
    clear   <= 1'b0;
    repeat (DRAIN_CYCLES) @(posedge clk_i);
    for (int i = 0; i < TL_NUM_EVENTS; i++) begin
      event_sel <= tl_event_e'(i);
      check_en  <= 1'b1;
      @(posedge clk_i);
    end
    check_en <= 1'b0;
    // The last comparison happens on that edge, so its result is read half a cycle later.
    @(negedge clk_i);
  endtask

  task automatic finish_test(input string name);
    int errs;
    sweep_counters();
    errs = sb_errors - errors_seen;
    errors_seen = sb_errors;
    if (errs == 0) begin
      tests_passed++;
      $display("Test %s: passed", name);
    end else begin
      tests_failed++;
      $display("Test %s: failed with %0d mismatches", name, errs);
    end
  endtask

  initial begin
    repeat (RESET_CYCLES) @(posedge clk_i);
    arst_n <= 1'b1;
    finish_test("1 reset");
    drive_traffic(A_ONLY_CYCLES, 1'b1, 1'b0, 50, -1);
    finish_test("2 channel A only");
    drive_traffic(D_ONLY_CYCLES, 1'b0, 1'b1, 50, -1);
    finish_test("3 channel D only");
    drive_traffic(MIXED_CYCLES, 1'b1, 1'b1, 85, -1);
    finish_test("4 mixed traffic");
    drive_traffic(CLEAR_CYCLES, 1'b1, 1'b1, 60, CLEAR_CYCLES / 2);
    finish_test("5 clear during traffic");
    $display("Tests: %0d passed, %0d failed", tests_passed, tests_failed);
    if (tests_failed == 0 && sb_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    int cycle_count;
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

endmodule

// ==== verification/tl_link_monitor_chk.sv ====
// Protocol checks of the TL-UL link monitor, bound into its top level.

`timescale 1ns/1ns

`include "tl_monitor_settings.svh"

module tl_link_monitor_chk (
  input  logic                       clk_i,
  input  logic                       arst_n,
  input  logic                       clear,
  input  tl_cover_pkg::tl_event_e    event_sel,
  input  logic [`TL_COUNT_WIDTH-1:0] event_count,
  input  logic                       event_flags [tl_cover_pkg::TL_NUM_EVENTS]
);

  import tl_cover_pkg::*;

  // All counters are zero one cycle after a clear, whichever is selected.
  clear_zeroes_counts: assert property (@(posedge clk_i) disable iff (!arst_n)
    clear |=> event_count == '0)
    else $error("event_count was not zero in the cycle after a clear");

  // A counter only holds or steps up by one.
  count_steps_by_one: assert property (@(posedge clk_i) disable iff (!arst_n)
    !clear ##1 $stable(event_sel) |->
      (event_count == $past(event_count) || event_count == $past(event_count) + 1'b1))
    else $error("event_count decreased or rose by more than one");

  a_flags_exclusive: assert property (@(posedge clk_i) disable iff (!arst_n)
    !(event_flags[EV_A_BACK_TO_BACK] && event_flags[EV_A_WITHDRAWN]))
    else $error("channel A back-to-back and withdrawn flags raised together");

  d_flags_exclusive: assert property (@(posedge clk_i) disable iff (!arst_n)
    !(event_flags[EV_D_BACK_TO_BACK] && event_flags[EV_D_WITHDRAWN]))
    else $error("channel D back-to-back and withdrawn flags raised together");

endmodule

bind tl_link_monitor tl_link_monitor_chk tl_link_monitor_chk_i (
  .clk_i(clk_i), .arst_n(arst_n), .clear(clear), .event_sel(event_sel),
  .event_count(event_count), .event_flags(event_flags)
);

// ==== verification/tl_link_monitor_scoreboard.sv ====
// Reference model of the TL-UL link monitor.
// Counts link events from the tap and compares the DUT counters during readout.

`timescale 1ns/1ns

`include "tl_monitor_settings.svh"

module tl_link_monitor_scoreboard (
  input  logic                        clk_i,
  input  logic                        arst_n,
  input  logic                        a_valid,
  input  logic                        a_ready,
  input  tl_msg_pkg::tl_a_opcode_e    a_opcode,
  input  logic [`TL_SIZE_WIDTH-1:0]   a_size,
  input  logic [`TL_SOURCE_WIDTH-1:0] a_source,
  input  logic [`TL_ADDR_WIDTH-1:0]   a_address,
  input  logic [`TL_DATA_WIDTH-1:0]   a_data,
  input  logic                        a_corrupt,
  input  logic                        d_valid,
  input  logic                        d_ready,
  input  tl_msg_pkg::tl_d_opcode_e    d_opcode,
  input  logic [`TL_SIZE_WIDTH-1:0]   d_size,
  input  logic [`TL_SOURCE_WIDTH-1:0] d_source,
  input  logic [`TL_SINK_WIDTH-1:0]   d_sink,
  input  logic [`TL_DATA_WIDTH-1:0]   d_data,
  input  logic                        d_corrupt,
  input  logic                        d_denied,
  input  logic                        clear,
  input  logic                        check_en,
  input  tl_cover_pkg::tl_event_e     event_sel,
  input  logic [`TL_COUNT_WIDTH-1:0]  event_count,
  output int                          error_count
);

  import tl_msg_pkg::*;
  import tl_cover_pkg::*;

  logic [`TL_COUNT_WIDTH-1:0] model_count [TL_NUM_EVENTS];
  // Events of a tap cycle reach the counters two clocks after the tap is sampled.
  bit flags_d1 [TL_NUM_EVENTS];
  bit flags_d2 [TL_NUM_EVENTS];

  // Per-channel history of the link.
  bit                          a_prev_valid, a_prev_accept, a_seen, a_declined;
  bit                          d_prev_valid, d_prev_accept, d_seen, d_declined;
  tl_a_opcode_e                a_acc_opcode;
  tl_d_opcode_e                d_acc_opcode;
  logic [`TL_SOURCE_WIDTH-1:0] a_acc_source;
  logic [`TL_SOURCE_WIDTH-1:0] d_acc_source;
  logic [`TL_A_BEAT_WIDTH-1:0] a_last;
  logic [`TL_D_BEAT_WIDTH-1:0] d_last;

  always @(posedge clk_i or negedge arst_n) begin : model
    bit now [TL_NUM_EVENTS];
    bit a_acc;
    bit d_acc;
    if (!arst_n) begin
      model_count = '{default: '0};
      flags_d1    = '{default: 1'b0};
      flags_d2    = '{default: 1'b0};
      {a_prev_valid, a_prev_accept, a_seen, a_declined} = '0;
      {d_prev_valid, d_prev_accept, d_seen, d_declined} = '0;
      error_count = 0;
    end else begin
      a_acc = a_valid && a_ready;
      d_acc = d_valid && d_ready;
      // The readout is checked against the model before this edge updates it.
      if (check_en && event_count !== model_count[event_sel]) begin
        $display("ERROR at %0t ns: event_count[%s] expected %0d, got %0d",
                 $time, event_sel.name(), model_count[event_sel], event_count);
        error_count++;
      end
      now[EV_A_BACK_TO_BACK]     = a_prev_accept && a_valid;
      now[EV_A_WITHDRAWN]        = a_prev_valid && !a_prev_accept && !a_valid;
      now[EV_A_OPCODE_REPEAT]    = a_valid && a_seen && a_opcode == a_acc_opcode;
      now[EV_A_SOURCE_REPEAT]    = a_valid && a_seen && a_source == a_acc_source;
      now[EV_A_CHANGED_DECLINED] = a_valid && a_declined &&
                                   {a_opcode, a_size, a_source, a_address, a_data} != a_last;
      now[EV_A_CORRUPT]          = a_valid && a_corrupt;
      now[EV_D_BACK_TO_BACK]     = d_prev_accept && d_valid;
      now[EV_D_WITHDRAWN]        = d_prev_valid && !d_prev_accept && !d_valid;
      now[EV_D_OPCODE_REPEAT]    = d_valid && d_seen && d_opcode == d_acc_opcode;
      now[EV_D_SOURCE_REPEAT]    = d_valid && d_seen && d_source == d_acc_source;
      now[EV_D_CHANGED_DECLINED] = d_valid && d_declined &&
                                   {d_opcode, d_size, d_source, d_sink, d_data} != d_last;
      now[EV_D_CORRUPT]          = d_valid && d_corrupt;
      now[EV_D_DENIED]           = d_valid && d_denied;
      now[EV_SIMULTANEOUS]       = a_acc && d_acc;
      for (int i = 0; i < TL_NUM_EVENTS; i++) begin
        if (clear) begin
          model_count[i] = '0;
        end else if (flags_d2[i] && model_count[i] != '1) begin
          model_count[i] = model_count[i] + 1'b1;
        end
      end
      flags_d2 = flags_d1;
      flags_d1 = now;
      a_prev_valid  = a_valid;
      a_prev_accept = a_acc;
      d_prev_valid  = d_valid;
      d_prev_accept = d_acc;
      if (a_valid) begin
        a_seen       = a_seen || a_acc;
        a_acc_opcode = a_acc ? a_opcode : a_acc_opcode;
        a_acc_source = a_acc ? a_source : a_acc_source;
        a_declined   = !a_acc;
        a_last       = {a_opcode, a_size, a_source, a_address, a_data};
      end
      if (d_valid) begin
        d_seen       = d_seen || d_acc;
        d_acc_opcode = d_acc ? d_opcode : d_acc_opcode;
        d_acc_source = d_acc ? d_source : d_acc_source;
        d_declined   = !d_acc;
        d_last       = {d_opcode, d_size, d_source, d_sink, d_data};
      end
    end
  end

endmodule

// ==== src/tl_link_monitor.sv ====
// Passive TL-UL link-event monitor.
// Taps channels A and D and counts protocol-coverage events in three stages.

`timescale 1ns/1ns

`include "tl_monitor_settings.svh"

module tl_link_monitor (
  input  logic                          clk_i,
  input  logic                          arst_n,
  // Channel A tap.
  input  logic                          a_valid,
  input  logic                          a_ready,
  input  tl_msg_pkg::tl_a_opcode_e      a_opcode,
  input  logic [`TL_SIZE_WIDTH-1:0]     a_size,
  input  logic [`TL_SOURCE_WIDTH-1:0]   a_source,
  input  logic [`TL_ADDR_WIDTH-1:0]     a_address,
  input  logic [`TL_DATA_WIDTH-1:0]     a_data,
  input  logic                          a_corrupt,
  // Channel D tap.
  input  logic                          d_valid,
  input  logic                          d_ready,
  input  tl_msg_pkg::tl_d_opcode_e      d_opcode,
  input  logic [`TL_SIZE_WIDTH-1:0]     d_size,
  input  logic [`TL_SOURCE_WIDTH-1:0]   d_source,
  input  logic [`TL_SINK_WIDTH-1:0]     d_sink,
  input  logic [`TL_DATA_WIDTH-1:0]     d_data,
  input  logic                          d_corrupt,
  input  logic                          d_denied,
  // Counter control and readout.
  input  logic                          clear,
  input  tl_cover_pkg::tl_event_e       event_sel,
  output logic [`TL_COUNT_WIDTH-1:0]    event_count
);

  import tl_msg_pkg::*;
  import tl_cover_pkg::*;

  // Stage 1 to stage 2.
  logic                        cap_a_valid;
  logic                        cap_a_accept;
  tl_a_opcode_e                cap_a_opcode;
  logic [`TL_SIZE_WIDTH-1:0]   cap_a_size;
  logic [`TL_SOURCE_WIDTH-1:0] cap_a_source;
  logic [`TL_ADDR_WIDTH-1:0]   cap_a_address;
  logic [`TL_DATA_WIDTH-1:0]   cap_a_data;
  logic                        cap_a_corrupt;
  logic                        cap_d_valid;
  logic                        cap_d_accept;
  tl_d_opcode_e                cap_d_opcode;
  logic [`TL_SIZE_WIDTH-1:0]   cap_d_size;
  logic [`TL_SOURCE_WIDTH-1:0] cap_d_source;
  logic [`TL_SINK_WIDTH-1:0]   cap_d_sink;
  logic [`TL_DATA_WIDTH-1:0]   cap_d_data;
  logic                        cap_d_corrupt;
  logic                        cap_d_denied;

  // Stage 2 to stage 3.
  logic event_flags [TL_NUM_EVENTS];

  // Every wire above carries the port name of both ends, so the stages connect by name.
  tl_tap_capture tl_tap_capture_i (.*);

  tl_beat_history tl_beat_history_i (.*);

  tl_event_counter tl_event_counter_i (.*);

endmodule

// ==== src/tl_event_counter.sv ====
// TL-UL monitor stage 3.
// Saturating per-event counters with a clear pulse and a selected readout.

`timescale 1ns/1ns

`include "tl_monitor_settings.svh"

module tl_event_counter (
  input  logic                        clk_i,
  input  logic                        arst_n,
  input  logic                        event_flags [tl_cover_pkg::TL_NUM_EVENTS],
  input  logic                        clear,
  input  tl_cover_pkg::tl_event_e     event_sel,
  output logic [`TL_COUNT_WIDTH-1:0]  event_count
);

  import tl_cover_pkg::*;

  logic [`TL_COUNT_WIDTH-1:0] counters     [TL_NUM_EVENTS];
  logic [`TL_COUNT_WIDTH-1:0] counter_next [TL_NUM_EVENTS];
  logic [TL_NUM_EVENTS-1:0]   counter_full;

  // A full counter ignores further flags of its event.
  always_comb begin
    for (int i = 0; i < TL_NUM_EVENTS; i++) begin
      counter_full[i] = &counters[i];
    end
  end

  // Clear wins over any increment in the same cycle.
  always_comb begin
    for (int i = 0; i < TL_NUM_EVENTS; i++) begin
      if (clear) begin
        counter_next[i] = '0;
      end else if (event_flags[i] && !counter_full[i]) begin
        counter_next[i] = counters[i] + 1'b1;
      end else begin
        counter_next[i] = counters[i];
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      counters <= '{default: '0};
    end else begin
      counters <= counter_next;
    end
  end

  // Readout is a plain mux. The two unused codes of the event enum read zero.
  always_comb begin
    if (event_sel < TL_NUM_EVENTS) begin
      event_count = counters[event_sel];
    end else begin
      event_count = '0;
    end
  end

endmodule

// ==== src/tl_beat_history.sv ====
// TL-UL monitor stage 2.
// Tracks per-channel beat history and raises one registered flag per link event.

`timescale 1ns/1ns

`include "tl_monitor_settings.svh"

module tl_beat_history (
  input  logic                          clk_i,
  input  logic                          arst_n,
  input  logic                          cap_a_valid,
  input  logic                          cap_a_accept,
  input  tl_msg_pkg::tl_a_opcode_e      cap_a_opcode,
  input  logic [`TL_SIZE_WIDTH-1:0]     cap_a_size,
  input  logic [`TL_SOURCE_WIDTH-1:0]   cap_a_source,
  input  logic [`TL_ADDR_WIDTH-1:0]     cap_a_address,
  input  logic [`TL_DATA_WIDTH-1:0]     cap_a_data,
  input  logic                          cap_a_corrupt,
  input  logic                          cap_d_valid,
  input  logic                          cap_d_accept,
  input  tl_msg_pkg::tl_d_opcode_e      cap_d_opcode,
  input  logic [`TL_SIZE_WIDTH-1:0]     cap_d_size,
  input  logic [`TL_SOURCE_WIDTH-1:0]   cap_d_source,
  input  logic [`TL_SINK_WIDTH-1:0]     cap_d_sink,
  input  logic [`TL_DATA_WIDTH-1:0]     cap_d_data,
  input  logic                          cap_d_corrupt,
  input  logic                          cap_d_denied,
  output logic                          event_flags [tl_cover_pkg::TL_NUM_EVENTS]
);

  import tl_cover_pkg::*;

  // Current beats, packed so that one rule updates every compared field.
  logic [`TL_A_BEAT_WIDTH-1:0] a_beat;
  logic [`TL_D_BEAT_WIDTH-1:0] d_beat;

  // Handshake of the previous cycle.
  logic a_prev_valid;
  logic a_prev_accept;
  logic d_prev_valid;
  logic d_prev_accept;

  // Last accepted beat and whether any beat was accepted since reset.
  logic                        a_acc_seen;
  logic                        d_acc_seen;
  logic [`TL_A_BEAT_WIDTH-1:0] a_acc_beat;
  logic [`TL_D_BEAT_WIDTH-1:0] d_acc_beat;
  logic [`TL_OPCODE_WIDTH-1:0] a_acc_opcode;
  logic [`TL_OPCODE_WIDTH-1:0] d_acc_opcode;
  logic [`TL_SOURCE_WIDTH-1:0] a_acc_source;
  logic [`TL_SOURCE_WIDTH-1:0] d_acc_source;

  // Last valid beat, flagged when it was declined.
  logic                        a_last_declined;
  logic                        d_last_declined;
  logic [`TL_A_BEAT_WIDTH-1:0] a_last_beat;
  logic [`TL_D_BEAT_WIDTH-1:0] d_last_beat;

  assign a_beat = {cap_a_opcode, cap_a_size, cap_a_source, cap_a_address, cap_a_data};
  assign d_beat = {cap_d_opcode, cap_d_size, cap_d_source, cap_d_sink, cap_d_data};

  // Opcode sits at the top of a beat, source just above address or sink.
  assign a_acc_opcode = a_acc_beat[`TL_A_BEAT_WIDTH-1 -: `TL_OPCODE_WIDTH];
  assign d_acc_opcode = d_acc_beat[`TL_D_BEAT_WIDTH-1 -: `TL_OPCODE_WIDTH];
  assign a_acc_source = a_acc_beat[`TL_ADDR_WIDTH + `TL_DATA_WIDTH +: `TL_SOURCE_WIDTH];
  assign d_acc_source = d_acc_beat[`TL_SINK_WIDTH + `TL_DATA_WIDTH +: `TL_SOURCE_WIDTH];

  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      a_prev_valid    <= 1'b0;
      a_prev_accept   <= 1'b0;
      d_prev_valid    <= 1'b0;
      d_prev_accept   <= 1'b0;
      a_acc_seen      <= 1'b0;
      d_acc_seen      <= 1'b0;
      a_last_declined <= 1'b0;
      d_last_declined <= 1'b0;
    end else begin
      a_prev_valid  <= cap_a_valid;
      a_prev_accept <= cap_a_accept;
      d_prev_valid  <= cap_d_valid;
      d_prev_accept <= cap_d_accept;
      if (cap_a_valid) begin
        a_acc_seen      <= a_acc_seen || cap_a_accept;
        a_last_declined <= !cap_a_accept;
      end
      if (cap_d_valid) begin
        d_acc_seen      <= d_acc_seen || cap_d_accept;
        d_last_declined <= !cap_d_accept;
      end
    end
  end

  // Every valid beat becomes the last beat; an accepted one also the accepted beat.
  always_ff @(posedge clk_i) begin
    if (cap_a_valid) a_last_beat <= a_beat;
    if (cap_a_accept) a_acc_beat <= a_beat;
    if (cap_d_valid) d_last_beat <= d_beat;
    if (cap_d_accept) d_acc_beat <= d_beat;
  end

  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      event_flags <= '{default: 1'b0};
    end else begin
      event_flags[EV_A_BACK_TO_BACK]     <= a_prev_accept && cap_a_valid;
      event_flags[EV_A_WITHDRAWN]        <= a_prev_valid && !a_prev_accept && !cap_a_valid;
      event_flags[EV_A_OPCODE_REPEAT]    <= cap_a_valid && a_acc_seen &&
                                            (cap_a_opcode == a_acc_opcode);
      event_flags[EV_A_SOURCE_REPEAT]    <= cap_a_valid && a_acc_seen &&
                                            (cap_a_source == a_acc_source);
      event_flags[EV_A_CHANGED_DECLINED] <= cap_a_valid && a_last_declined &&
                                            (a_beat != a_last_beat);
      event_flags[EV_A_CORRUPT]          <= cap_a_valid && cap_a_corrupt;
      event_flags[EV_D_BACK_TO_BACK]     <= d_prev_accept && cap_d_valid;
      event_flags[EV_D_WITHDRAWN]        <= d_prev_valid && !d_prev_accept && !cap_d_valid;
      event_flags[EV_D_OPCODE_REPEAT]    <= cap_d_valid && d_acc_seen &&
                                            (cap_d_opcode == d_acc_opcode);
      event_flags[EV_D_SOURCE_REPEAT]    <= cap_d_valid && d_acc_seen &&
                                            (cap_d_source == d_acc_source);
      event_flags[EV_D_CHANGED_DECLINED] <= cap_d_valid && d_last_declined &&
                                            (d_beat != d_last_beat);
      event_flags[EV_D_CORRUPT]          <= cap_d_valid && cap_d_corrupt;
      event_flags[EV_D_DENIED]           <= cap_d_valid && cap_d_denied;
      event_flags[EV_SIMULTANEOUS]       <= cap_a_accept && cap_d_accept;
    end
  end

endmodule

// ==== src/tl_tap_capture.sv ====
// TL-UL monitor stage 1.
// Registers the tapped A and D channels and forms the accept strobes.

`timescale 1ns/1ns

`include "tl_monitor_settings.svh"

module tl_tap_capture (
  input  logic                          clk_i,
  input  logic                          arst_n,
  // Channel A tap.
  input  logic                          a_valid,
  input  logic                          a_ready,
  input  tl_msg_pkg::tl_a_opcode_e      a_opcode,
  input  logic [`TL_SIZE_WIDTH-1:0]     a_size,
  input  logic [`TL_SOURCE_WIDTH-1:0]   a_source,
  input  logic [`TL_ADDR_WIDTH-1:0]     a_address,
  input  logic [`TL_DATA_WIDTH-1:0]     a_data,
  input  logic                          a_corrupt,
  // Channel D tap.
  input  logic                          d_valid,
  input  logic                          d_ready,
  input  tl_msg_pkg::tl_d_opcode_e      d_opcode,
  input  logic [`TL_SIZE_WIDTH-1:0]     d_size,
  input  logic [`TL_SOURCE_WIDTH-1:0]   d_source,
  input  logic [`TL_SINK_WIDTH-1:0]     d_sink,
  input  logic [`TL_DATA_WIDTH-1:0]     d_data,
  input  logic                          d_corrupt,
  input  logic                          d_denied,
  // Registered channel A.
  output logic                          cap_a_valid,
  output logic                          cap_a_accept,
  output tl_msg_pkg::tl_a_opcode_e      cap_a_opcode,
  output logic [`TL_SIZE_WIDTH-1:0]     cap_a_size,
  output logic [`TL_SOURCE_WIDTH-1:0]   cap_a_source,
  output logic [`TL_ADDR_WIDTH-1:0]     cap_a_address,
  output logic [`TL_DATA_WIDTH-1:0]     cap_a_data,
  output logic                          cap_a_corrupt,
  // Registered channel D.
  output logic                          cap_d_valid,
  output logic                          cap_d_accept,
  output tl_msg_pkg::tl_d_opcode_e      cap_d_opcode,
  output logic [`TL_SIZE_WIDTH-1:0]     cap_d_size,
  output logic [`TL_SOURCE_WIDTH-1:0]   cap_d_source,
  output logic [`TL_SINK_WIDTH-1:0]     cap_d_sink,
  output logic [`TL_DATA_WIDTH-1:0]     cap_d_data,
  output logic                          cap_d_corrupt,
  output logic                          cap_d_denied
);

  // Handshake state. A ready without valid is not a transfer, so the
  // accept strobe is qualified here once for all later stages.
  always_ff @(posedge clk_i or negedge arst_n) begin
    if (!arst_n) begin
      cap_a_valid  <= 1'b0;
      cap_a_accept <= 1'b0;
      cap_d_valid  <= 1'b0;
      cap_d_accept <= 1'b0;
    end else begin
      cap_a_valid  <= a_valid;
      cap_a_accept <= a_valid && a_ready;
      cap_d_valid  <= d_valid;
      cap_d_accept <= d_valid && d_ready;
    end
  end

  // Payload follows the link only while the channel is valid.
  // Idle cycles keep the last beat in place.
  always_ff @(posedge clk_i) begin
    if (a_valid) begin
      cap_a_opcode  <= a_opcode;
      cap_a_size    <= a_size;
      cap_a_source  <= a_source;
      cap_a_address <= a_address;
      cap_a_data    <= a_data;
      cap_a_corrupt <= a_corrupt;
    end
    if (d_valid) begin
      cap_d_opcode  <= d_opcode;
      cap_d_size    <= d_size;
      cap_d_source  <= d_source;
      cap_d_sink    <= d_sink;
      cap_d_data    <= d_data;
      cap_d_corrupt <= d_corrupt;
      cap_d_denied  <= d_denied;
    end
  end

endmodule

// ==== src/tl_cover_pkg.sv ====
// Link-event types of the TL-UL monitor.
// One enum value per counted event, which also indexes the counters.

package tl_cover_pkg;

  // Number of counted events and width of the event flag vector.
  localparam int unsigned TL_NUM_EVENTS = 14;

  typedef enum logic [3:0] {
    // Channel A.
    EV_A_BACK_TO_BACK     = 4'd0,
    EV_A_WITHDRAWN        = 4'd1,
    EV_A_OPCODE_REPEAT    = 4'd2,
    EV_A_SOURCE_REPEAT    = 4'd3,
    EV_A_CHANGED_DECLINED = 4'd4,
    EV_A_CORRUPT          = 4'd5,
    // Channel D.
    EV_D_BACK_TO_BACK     = 4'd6,
    EV_D_WITHDRAWN        = 4'd7,
    EV_D_OPCODE_REPEAT    = 4'd8,
    EV_D_SOURCE_REPEAT    = 4'd9,
    EV_D_CHANGED_DECLINED = 4'd10,
    EV_D_CORRUPT          = 4'd11,
    EV_D_DENIED           = 4'd12,
    // A and D accepted in the same cycle.
    EV_SIMULTANEOUS       = 4'd13
  } tl_event_e;

endpackage

// ==== src/tl_msg_pkg.sv ====
// TL-UL message types.
// Opcode encodings of the A and D channels as the TileLink spec defines them.

`include "tl_monitor_settings.svh"

package tl_msg_pkg;

  // Requests on channel A.
  // Only the uncached subset is listed, so the atomic and hint
  // opcodes of TL-UH are not part of this type.
  typedef enum logic [`TL_OPCODE_WIDTH-1:0] {
    // Write of a full, naturally aligned block.
    PutFullData    = 3'h0,
    // Write with a byte mask. The mask itself is not tapped.
    PutPartialData = 3'h1,
    // Read request.
    Get            = 3'h4
  } tl_a_opcode_e;

  // Responses on channel D.
  // Every request on A is answered by exactly one of these.
  typedef enum logic [`TL_OPCODE_WIDTH-1:0] {
    // Answer to a Put, carries no data.
    AccessAck     = 3'h0,
    // Answer to a Get, carries the read data.
    AccessAckData = 3'h1
  } tl_d_opcode_e;

endpackage

// ==== src/tl_monitor_settings.svh ====
// TL-UL link monitor settings.
// Field widths of the tapped link and the size of the event counters.

`ifndef TL_MONITOR_SETTINGS_SVH
`define TL_MONITOR_SETTINGS_SVH

// Field widths of the tapped link.
`define TL_ADDR_WIDTH   32
`define TL_DATA_WIDTH   32
`define TL_SOURCE_WIDTH 4
`define TL_SINK_WIDTH   1
`define TL_SIZE_WIDTH   2

// Both the A and the D channel carry a 3-bit opcode.
`define TL_OPCODE_WIDTH 3

// Each event counter saturates at its all-ones value.
`define TL_COUNT_WIDTH  16

// Compared fields of one beat, packed as {opcode, size, source, address, data} on A
// and as {opcode, size, source, sink, data} on D.
`define TL_A_BEAT_WIDTH (`TL_OPCODE_WIDTH + `TL_SIZE_WIDTH + `TL_SOURCE_WIDTH + \
                         `TL_ADDR_WIDTH + `TL_DATA_WIDTH)
`define TL_D_BEAT_WIDTH (`TL_OPCODE_WIDTH + `TL_SIZE_WIDTH + `TL_SOURCE_WIDTH + \
                         `TL_SINK_WIDTH + `TL_DATA_WIDTH)

`endif
